// File: tc_pkg.sv
package tc_pkg;

    localparam int DIM    = 4;
    localparam int ELEM_W = 8;
    localparam int ACC_W  = 32;
    localparam int BEAT_W = 256;
    localparam int ROW_W  = $clog2(DIM);
    localparam int STEP_W = 4;

    localparam logic [2:0] BEAT_SIZE = 3'd5;   // 32 bytes per beat

    localparam logic [31:0] BASE_C = 32'h0001_0000;
    localparam logic [31:0] BASE_A = 32'h0010_0000;
    localparam logic [31:0] BASE_B = 32'h0100_0000;

    localparam int BEATS_C = 2;
    localparam int BEATS_A = 1;
    localparam int BEATS_B = 1;

    localparam int COMPUTE_CYCLES = 3 * DIM - 1;   // Last product reaches PE(3,3)

    typedef enum logic [2:0] {
        MAT_C = 3'b001,
        MAT_B = 3'b010,
        MAT_A = 3'b100
    } mat_t;

    typedef enum logic [2:0] {
        IDLE,
        READ_C,
        LOAD_A,
        LOAD_B,
        COMPUTE,
        WRITE_BACK,
        FINISH
    } state_t;

    typedef struct packed {
        mat_t        sel;
        logic [31:0] base;
        logic [5:0]  burst_num;    // Beats minus one
        logic [2:0]  burst_size;
    } rd_req_t;

    typedef struct packed {
        logic [BEAT_W-1:0] data;
        logic [5:0]        id;     // Beat index in burst
    } rd_beat_t;

    typedef struct packed {
        logic [ROW_W-1:0]             row;
        logic [DIM-1:0][ACC_W-1:0]    data;   // Element j at bits 32j
    } res_row_t;

endpackage

// File: tc_mac_pe.sv
`timescale 1ns/1ps

module tc_mac_pe (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      load,
    input  logic [tc_pkg::ACC_W-1:0]  c_init,
    input  logic [tc_pkg::ELEM_W-1:0] a_in,
    input  logic [tc_pkg::ELEM_W-1:0] b_in,
    output logic [tc_pkg::ELEM_W-1:0] a_out,
    output logic [tc_pkg::ELEM_W-1:0] b_out,
    output logic [tc_pkg::ACC_W-1:0]  acc
);
    import tc_pkg::*;

    logic signed [ACC_W-1:0] prod;

    assign prod = $signed(a_in) * $signed(b_in);   // Sign-extended to ACC_W

    always_ff @(posedge clk) begin
        if (load) begin
            acc <= c_init;
        end else begin
            acc <= acc + prod;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            a_out <= '0;
            b_out <= '0;
        end else begin
            a_out <= a_in;   // To the right
            b_out <= b_in;   // Downward
        end
    end

endmodule

// File: tc_systolic_array.sv
`timescale 1ns/1ps

module tc_systolic_array (
    input  logic                                                       clk,
    input  logic                                                       rst,
    input  logic                                                       compute_en,
    input  logic [tc_pkg::DIM-1:0][tc_pkg::DIM-1:0][tc_pkg::ACC_W-1:0]  c_mat,
    input  logic [tc_pkg::DIM-1:0][tc_pkg::ELEM_W-1:0]                  a_left,
    input  logic [tc_pkg::DIM-1:0][tc_pkg::ELEM_W-1:0]                  b_up,
    input  logic [tc_pkg::ROW_W-1:0]                                   rd_row,
    output logic [tc_pkg::DIM-1:0][tc_pkg::ACC_W-1:0]                  row_data
);
    import tc_pkg::*;

    logic                                   compute_en_d;
    logic                                   load;
    logic [DIM-1:0][DIM:0][ELEM_W-1:0]      a_h;   // Horizontal links per row
    logic [DIM:0][DIM-1:0][ELEM_W-1:0]      b_v;   // Vertical links per column
    logic [DIM-1:0][DIM-1:0][ACC_W-1:0]     acc;

    always_ff @(posedge clk) begin
        if (!rst) begin
            compute_en_d <= 1'b0;
        end else begin
            compute_en_d <= compute_en;
        end
    end

    assign load = compute_en && !compute_en_d;   // C preload on first step

    for (genvar i = 0; i < DIM; i++) begin : g_row
        assign a_h[i][0] = a_left[i];
        assign b_v[0][i] = b_up[i];
        for (genvar j = 0; j < DIM; j++) begin : g_col
            tc_mac_pe u_pe (
                .clk    (clk),
                .rst    (rst),
                .load   (load),
                .c_init (c_mat[i][j]),
                .a_in   (a_h[i][j]),
                .b_in   (b_v[i][j]),
                .a_out  (a_h[i][j+1]),
                .b_out  (b_v[i+1][j]),
                .acc    (acc[i][j])
            );
        end
    end

    assign row_data = acc[rd_row];

    // Skew unit must drain to zero outside compute
    a_edge_idle_zero: assert property (@(posedge clk) disable iff (!rst)
        !compute_en |-> (a_left == '0) && (b_up == '0));

endmodule

// File: tc_operand_buffer.sv
`timescale 1ns/1ps

module tc_operand_buffer (
    input  logic                                                       clk,
    input  logic                                                       rst,
    input  logic                                                       beat_valid,
    input  tc_pkg::rd_beat_t                                           beat,
    input  tc_pkg::mat_t                                               cur_mat,
    output logic [tc_pkg::DIM-1:0][tc_pkg::DIM-1:0][tc_pkg::ELEM_W-1:0] a_mat,
    output logic [tc_pkg::DIM-1:0][tc_pkg::DIM-1:0][tc_pkg::ELEM_W-1:0] b_mat,
    output logic [tc_pkg::DIM-1:0][tc_pkg::DIM-1:0][tc_pkg::ACC_W-1:0]  c_mat
);
    import tc_pkg::*;

    logic [5:0] beat_limit;

    always_ff @(posedge clk) begin
        if (beat_valid) begin
            for (int i = 0; i < DIM; i++) begin
                for (int j = 0; j < DIM; j++) begin
                    case (cur_mat)
                        MAT_A: a_mat[i][j] <= beat.data[ELEM_W*(DIM*i+j) +: ELEM_W];
                        MAT_B: b_mat[i][j] <= beat.data[ELEM_W*(DIM*i+j) +: ELEM_W];
                        default: begin
                            // Two C rows per beat
                            if (i / 2 == int'(beat.id[0])) begin
                                c_mat[i][j] <= beat.data[ACC_W*(DIM*(i%2)+j) +: ACC_W];
                            end
                        end
                    endcase
                end
            end
        end
    end

    always_comb begin
        case (cur_mat)
            MAT_A:   beat_limit = 6'(BEATS_A);
            MAT_B:   beat_limit = 6'(BEATS_B);
            default: beat_limit = 6'(BEATS_C);
        endcase
    end

    a_beat_id_range: assert property (@(posedge clk) disable iff (!rst)
        beat_valid |-> beat.id < beat_limit);

endmodule

// File: tc_operand_skew.sv
`timescale 1ns/1ps

module tc_operand_skew (
    input  logic                                                       clk,
    input  logic                                                       rst,
    input  logic                                                       compute_en,
    input  logic [tc_pkg::DIM-1:0][tc_pkg::DIM-1:0][tc_pkg::ELEM_W-1:0] a_mat,
    input  logic [tc_pkg::DIM-1:0][tc_pkg::DIM-1:0][tc_pkg::ELEM_W-1:0] b_mat,
    output logic [tc_pkg::DIM-1:0][tc_pkg::ELEM_W-1:0]                  a_left,
    output logic [tc_pkg::DIM-1:0][tc_pkg::ELEM_W-1:0]                  b_up
);
    import tc_pkg::*;

    logic [STEP_W-1:0]          step;
    logic [DIM-1:0][ELEM_W-1:0] a_next;
    logic [DIM-1:0][ELEM_W-1:0] b_next;

    // Step is zero on the first compute cycle
    always_ff @(posedge clk) begin
        if (!rst || !compute_en) begin
            step <= '0;
        end else begin
            step <= step + 1'b1;
        end
    end

    // Row i and column j are delayed by i and j steps
    always_comb begin
        int k;
        a_next = '0;
        b_next = '0;
        for (int i = 0; i < DIM; i++) begin
            k = int'(step) - i;
            if (compute_en && k >= 0 && k < DIM) begin
                a_next[i] = a_mat[i][k[ROW_W-1:0]];   // A(i, t-i)
                b_next[i] = b_mat[k[ROW_W-1:0]][i];   // B(t-j, j)
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            a_left <= '0;
            b_up   <= '0;
        end else begin
            a_left <= a_next;
            b_up   <= b_next;
        end
    end

endmodule

// File: tc_scheduler.sv
`timescale 1ns/1ps

module tc_scheduler (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  logic                     req_ready,
    input  logic                     burst_finish,
    output logic                     req_valid,
    output tc_pkg::rd_req_t          req,
    output tc_pkg::mat_t             cur_mat,
    output logic                     compute_en,
    output logic                     res_valid,
    output logic [tc_pkg::ROW_W-1:0] rd_row,
    output logic                     done
);
    import tc_pkg::*;

    state_t           state;
    logic [STEP_W-1:0] cnt;   // Compute cycles, then writeback rows

    function automatic rd_req_t req_for(input mat_t sel);
        rd_req_t r;
        r.sel        = sel;
        r.burst_size = BEAT_SIZE;
        case (sel)
            MAT_A: begin
                r.base      = BASE_A;
                r.burst_num = 6'(BEATS_A - 1);
            end
            MAT_B: begin
                r.base      = BASE_B;
                r.burst_num = 6'(BEATS_B - 1);
            end
            default: begin
                r.base      = BASE_C;
                r.burst_num = 6'(BEATS_C - 1);
            end
        endcase
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= IDLE;
            req_valid <= 1'b0;
            cnt       <= '0;
        end else begin
            case (state)
                IDLE: begin
                    cnt <= '0;
                    if (start) begin
                        state     <= READ_C;
                        req       <= req_for(MAT_C);
                        req_valid <= 1'b1;
                    end
                end
                READ_C, LOAD_A: begin
                    if (burst_finish) begin
                        state     <= (state == READ_C) ? LOAD_A : LOAD_B;
                        req       <= req_for((state == READ_C) ? MAT_A : MAT_B);
                        req_valid <= 1'b1;
                    end else if (req_ready) begin
                        req_valid <= 1'b0;   // Address phase taken
                    end
                end
                LOAD_B: begin
                    if (req_ready) begin
                        req_valid <= 1'b0;
                    end
                    if (burst_finish) begin
                        state     <= COMPUTE;
                        req_valid <= 1'b0;
                        cnt       <= '0;
                    end
                end
                COMPUTE: begin
                    if (cnt == STEP_W'(COMPUTE_CYCLES - 1)) begin
                        state <= WRITE_BACK;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                WRITE_BACK: begin
                    if (cnt == STEP_W'(DIM - 1)) begin
                        state <= FINISH;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;   // FINISH lasts one cycle
                end
            endcase
        end
    end

    always_comb begin
        case (state)
            LOAD_A:  cur_mat = MAT_A;
            LOAD_B:  cur_mat = MAT_B;
            default: cur_mat = MAT_C;
        endcase
    end

    assign compute_en = (state == COMPUTE);
    assign res_valid  = (state == WRITE_BACK);
    assign rd_row     = cnt[ROW_W-1:0];
    assign done       = (state == FINISH);

    // Held request must not change before it is taken
    a_req_stable: assert property (@(posedge clk) disable iff (!rst)
        req_valid && !req_ready |=> req_valid && $stable(req));

endmodule

// File: tensor_core.sv
`timescale 1ns/1ps

module tensor_core (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    output logic              req_valid,
    output tc_pkg::rd_req_t   req,
    input  logic              req_ready,
    input  logic              beat_valid,
    input  tc_pkg::rd_beat_t  beat,
    input  logic              burst_finish,
    output logic              res_valid,
    output tc_pkg::res_row_t  res,
    output logic              done
);
    import tc_pkg::*;

    mat_t                                   cur_mat;
    logic                                   compute_en;
    logic [ROW_W-1:0]                       rd_row;
    logic [DIM-1:0][DIM-1:0][ELEM_W-1:0]    a_mat;
    logic [DIM-1:0][DIM-1:0][ELEM_W-1:0]    b_mat;
    logic [DIM-1:0][DIM-1:0][ACC_W-1:0]     c_mat;
    logic [DIM-1:0][ELEM_W-1:0]             a_left;
    logic [DIM-1:0][ELEM_W-1:0]             b_up;
    logic [DIM-1:0][ACC_W-1:0]              row_data;

    tc_scheduler u_scheduler (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .req_ready    (req_ready),
        .burst_finish (burst_finish),
        .req_valid    (req_valid),
        .req          (req),
        .cur_mat      (cur_mat),
        .compute_en   (compute_en),
        .res_valid    (res_valid),
        .rd_row       (rd_row),
        .done         (done)
    );

    tc_operand_buffer u_operand_buffer (
        .clk        (clk),
        .rst        (rst),
        .beat_valid (beat_valid),
        .beat       (beat),
        .cur_mat    (cur_mat),
        .a_mat      (a_mat),
        .b_mat      (b_mat),
        .c_mat      (c_mat)
    );

    tc_operand_skew u_operand_skew (
        .clk        (clk),
        .rst        (rst),
        .compute_en (compute_en),
        .a_mat      (a_mat),
        .b_mat      (b_mat),
        .a_left     (a_left),
        .b_up       (b_up)
    );

    tc_systolic_array u_systolic_array (
        .clk        (clk),
        .rst        (rst),
        .compute_en (compute_en),
        .c_mat      (c_mat),
        .a_left     (a_left),
        .b_up       (b_up),
        .rd_row     (rd_row),
        .row_data   (row_data)
    );

    assign res.row  = rd_row;
    assign res.data = row_data;

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    initial begin
        rst = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;   // Released on a falling edge
    end

endmodule

// File: tb_tensor_core.sv
`timescale 1ns/1ps

module tb_tensor_core;
    import tc_pkg::*;

    localparam int WAIT_LIMIT     = 200;
    localparam int FIRST_RES_WAIT = 11;   // Falling edges spent in COMPUTE

    logic     clk;
    logic     rst;
    logic     start;
    logic     req_valid;
    rd_req_t  req;
    logic     req_ready;
    logic     beat_valid;
    rd_beat_t beat;
    logic     burst_finish;
    logic     res_valid;
    res_row_t res;
    logic     done;

    logic signed [7:0]  a_m [4][4];
    logic signed [7:0]  b_m [4][4];
    logic signed [31:0] c_m [4][4];

    tb_clock_gen u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    tensor_core u_dut (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .req_valid    (req_valid),
        .req          (req),
        .req_ready    (req_ready),
        .beat_valid   (beat_valid),
        .beat         (beat),
        .burst_finish (burst_finish),
        .res_valid    (res_valid),
        .res          (res),
        .done         (done)
    );

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp_val,
                            input string msg);
        if (got !== exp_val) begin
            $display("ERR %0t: %s, got %0h, expected %0h", $time, msg, got, exp_val);
            $display("TESTBENCH FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timed out at %0t while waiting for %s", $time, what);
        $display("TESTBENCH FAILED");
        $fatal(1, "Wait limit exceeded");
    endtask

    // C beat b carries rows 2b and 2b+1, A and B use the low 16 bytes
    function automatic logic [BEAT_W-1:0] build_beat(input mat_t sel, input int id);
        logic [BEAT_W-1:0] d;
        d = '0;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                if (sel == MAT_C) begin
                    if (i / 2 == id) begin
                        d[32*(4*(i%2)+j) +: 32] = c_m[i][j];
                    end
                end else if (sel == MAT_A) begin
                    d[8*(4*i+j) +: 8] = a_m[i][j];
                end else begin
                    d[8*(4*i+j) +: 8] = b_m[i][j];
                end
            end
        end
        if (sel != MAT_C) begin
            d[BEAT_W-1:128] = {4{32'($urandom)}};   // Junk the core must ignore
        end
        return d;
    endfunction

    function automatic logic [31:0] ref_elem(input int i, input int j);
        int sum;
        sum = c_m[i][j];
        for (int k = 0; k < 4; k++) begin
            sum += int'(a_m[i][k]) * int'(b_m[k][j]);
        end
        return 32'(sum);
    endfunction

    task automatic serve_request(input mat_t sel, input logic [31:0] base, input int beats,
                                 input bit stall, input bit gaps);
        int      cycles;
        int      hold;
        rd_req_t exp_req;
        exp_req.sel        = sel;
        exp_req.base       = base;
        exp_req.burst_num  = 6'(beats - 1);
        exp_req.burst_size = 3'd5;
        cycles = 0;
        while (!req_valid) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_on_timeout("a read request");
            end
        end
        check_eq(64'(req.sel), 64'(sel), "request matrix select");
        check_eq(64'(req.base), 64'(base), "request base address");
        check_eq(64'(req.burst_num), 64'(beats - 1), "request burst_num");
        check_eq(64'(req.burst_size), 64'(5), "request burst_size");
        hold = stall ? int'($urandom_range(6, 1)) : 0;
        repeat (hold) begin
            @(negedge clk);
            check_eq(64'(req_valid), 64'(1), "req_valid held while not ready");
            check_eq(64'(req), 64'(exp_req), "request stable while not ready");
        end
        req_ready = 1'b1;
        @(negedge clk);
        req_ready = 1'b0;
        check_eq(64'(req_valid), 64'(0), "req_valid drops after ready");
        for (int b = 0; b < beats; b++) begin
            if (gaps) begin
                repeat ($urandom_range(3, 0)) @(negedge clk);
            end
            beat_valid = 1'b1;
            beat.data  = build_beat(sel, b);
            beat.id    = 6'(b);
            @(negedge clk);
            beat_valid = 1'b0;
        end
        if (gaps) begin
            repeat ($urandom_range(2, 0)) @(negedge clk);
        end
        burst_finish = 1'b1;
        @(negedge clk);
        burst_finish = 1'b0;
    endtask

    task automatic collect_results();
        int cycles;
        cycles = 0;
        while (!res_valid) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_on_timeout("the first result row");
            end
        end
        check_eq(64'(cycles), 64'(FIRST_RES_WAIT), "compute to first row latency");
        for (int r = 0; r < 4; r++) begin
            check_eq(64'(res_valid), 64'(1), "res_valid during writeback");
            check_eq(64'(res.row), 64'(r), "result row index");
            for (int j = 0; j < 4; j++) begin
                check_eq(64'(res.data[j]), 64'(ref_elem(r, j)),
                         $sformatf("row %0d element %0d", r, j));
            end
            check_eq(64'(done), 64'(0), "done during writeback");
            @(negedge clk);
        end
        check_eq(64'(res_valid), 64'(0), "res_valid after four rows");
        check_eq(64'(done), 64'(1), "done after last row");
        @(negedge clk);
        check_eq(64'(done), 64'(0), "done lasts one cycle");
    endtask

    task automatic run_matmul(input bit stall, input bit gaps);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_eq(64'(req_valid), 64'(1), "req_valid one cycle after start");
        serve_request(MAT_C, BASE_C, 2, stall, gaps);
        serve_request(MAT_A, BASE_A, 1, stall, gaps);
        serve_request(MAT_B, BASE_B, 1, stall, gaps);
        collect_results();
    endtask

    task automatic fill_random();
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                a_m[i][j] = 8'($urandom);
                b_m[i][j] = 8'($urandom);
                c_m[i][j] = 32'($urandom);
            end
        end
    endtask

    task automatic after_reset_idle();
        int cycles;
        cycles = 0;
        while (!rst) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_on_timeout("reset release");
            end
        end
        repeat (5) begin
            @(negedge clk);
            check_eq(64'(req_valid), 64'(0), "req_valid low after reset");
            check_eq(64'(res_valid), 64'(0), "res_valid low after reset");
            check_eq(64'(done), 64'(0), "done low after reset");
        end
    endtask

    task automatic identity_run();
        fill_random();
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                a_m[i][j] = (i == j) ? 8'sd1 : 8'sd0;
                c_m[i][j] = 32'sd0;
            end
        end
        run_matmul(1'b0, 1'b0);   // Rows must equal B
    endtask

    initial begin
        start        = 1'b0;
        req_ready    = 1'b0;
        beat_valid   = 1'b0;
        beat         = '0;
        burst_finish = 1'b0;
        void'($urandom(31304));
        after_reset_idle();
        fill_random();
        run_matmul(1'b1, 1'b0);   // Request order and ready stalls
        identity_run();
        fill_random();
        run_matmul(1'b0, 1'b1);
        fill_random();
        run_matmul(1'b1, 1'b1);
        fill_random();
        run_matmul(1'b0, 1'b1);   // Back to back, new data
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: files.f
tc_pkg.sv
tc_mac_pe.sv
tc_systolic_array.sv
tc_operand_buffer.sv
tc_operand_skew.sv
tc_scheduler.sv
tensor_core.sv
tb_clock_gen.sv
tb_tensor_core.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tb_tensor_core -o tb_sim \
    && ./obj_dir/tb_sim 2>&1 | tee sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "Build or simulation did not finish"; exit 1; }
echo "Simulation passed"
exit 0
